/* src/ddr_geom_pkg.sv */
// DDR memory geometry
// full field widths of the memory address, the matching field types,
// the CSR width fields and the burst constants used for address stepping

`default_nettype none

package ddr_geom_pkg;

    //////////////////////
    // memory address fields
    localparam int COL_W  = 12;
    localparam int ROW_W  = 16;
    localparam int BANK_W = 3;
    localparam int CS_W   = 2;

    typedef logic [COL_W-1:0]  col_t;
    typedef logic [ROW_W-1:0]  row_t;
    typedef logic [BANK_W-1:0] bank_t;
    typedef logic [CS_W-1:0]   cs_t;

    //////////////////////
    // csr width fields
    typedef logic [3:0] csr_col_w_t;    // 8 to 12
    typedef logic [4:0] csr_row_w_t;    // 12 to 16
    typedef logic [1:0] csr_bank_w_t;   // 2 to 3
    typedef logic [1:0] csr_cs_w_t;     // 0 to 2, zero means a single chip

    // 1 selects chip-bank-row-col, anything else chip-row-bank-col
    typedef logic [1:0] addr_order_t;

    // one memory burst covers BURST_COLS columns
    localparam int BURST_COLS = 8;
    localparam int BURST_LSB  = 3;

endpackage

`default_nettype wire

/* src/ddr_cmd_pkg.sv */
// DDR command side definitions
// local address and request size types, half-rate beat constants
// and the state encoding of the burst splitter

`default_nettype none

package ddr_cmd_pkg;

    //////////////////////
    // local interface
    localparam int LOCAL_ADDR_W = 33;
    typedef logic [LOCAL_ADDR_W-1:0] local_addr_t;

    // half-rate controller, so one local beat covers 4 columns
    localparam int DWIDTH_RATIO = 4;
    localparam int COL_SHIFT    = $clog2(DWIDTH_RATIO);

    //////////////////////
    // sizes in local beats
    localparam int SIZE_W = 6;
    typedef logic [SIZE_W-1:0] local_size_t;    // 1 to 63
    typedef logic [1:0]        cmd_size_t;      // 1 or 2

    localparam int BEATS_PER_BURST = 2;     // a burst of 8 at ratio 4

    //////////////////////
    // splitter state
    typedef enum logic
    {
        IDLE,
        SPLIT
    } split_state_t;

endpackage

`default_nettype wire

/* src/ddr_cmd_ifs.sv */
// internal bundles of the command generator
// csr_cfg_if carries the static CSR geometry, mem_addr_if one
// memory address split into chip, bank, row and column

`default_nettype none

interface csr_cfg_if;

    ddr_geom_pkg::addr_order_t addr_order;
    ddr_geom_pkg::csr_col_w_t  col_width;
    ddr_geom_pkg::csr_row_w_t  row_width;
    ddr_geom_pkg::csr_bank_w_t bank_width;
    ddr_geom_pkg::csr_cs_w_t   cs_width;

    modport cfg_in
    (
        input addr_order,
        input col_width,
        input row_width,
        input bank_width,
        input cs_width
    );

endinterface

interface mem_addr_if;

    ddr_geom_pkg::cs_t   cs;
    ddr_geom_pkg::bank_t bank;
    ddr_geom_pkg::row_t  row;
    ddr_geom_pkg::col_t  col;

    modport src (output cs, output bank, output row, output col);
    modport snk (input cs, input bank, input row, input col);

endinterface

`default_nettype wire

/* src/ddr_addr_map.sv */
// local address remap
// splits the local address into chip, bank, row and column using the
// CSR widths and address order; purely combinational

`default_nettype none

module ddr_addr_map
(
    csr_cfg_if.cfg_in                cfg,
    input  ddr_cmd_pkg::local_addr_t local_addr,
    mem_addr_if.src                  addr
);

    logic [5:0]               col_bits;     // local bits feeding the column
    logic [5:0]               row_lsb;
    logic [5:0]               bank_lsb;
    logic [5:0]               cs_lsb;
    ddr_cmd_pkg::local_addr_t col_src;
    ddr_cmd_pkg::local_addr_t row_src;
    ddr_cmd_pkg::local_addr_t bank_src;
    ddr_cmd_pkg::local_addr_t cs_src;

    // ones in the lowest n bits
    function automatic logic [31:0] low_mask(input logic [5:0] n);
        return (32'd1 << n) - 32'd1;
    endfunction

    //////////////////////
    // field positions

    always_comb
    begin
        col_bits = 6'(cfg.col_width) - 6'(ddr_cmd_pkg::COL_SHIFT);
        if (cfg.addr_order == 2'd1)
        begin
            row_lsb  = col_bits;                        // cs, bank, row, col
            bank_lsb = col_bits + 6'(cfg.row_width);
        end
        else
        begin
            bank_lsb = col_bits;                        // cs, row, bank, col
            row_lsb  = col_bits + 6'(cfg.bank_width);
        end
        // chip always sits on top of the other three
        cs_lsb = col_bits + 6'(cfg.row_width) + 6'(cfg.bank_width);
    end

    //////////////////////
    // field extraction

    // bits above the configured width are masked off
    assign col_src  = local_addr & ddr_cmd_pkg::local_addr_t'(low_mask(col_bits));
    assign row_src  = (local_addr >> row_lsb)
                    & ddr_cmd_pkg::local_addr_t'(low_mask(6'(cfg.row_width)));
    assign bank_src = (local_addr >> bank_lsb)
                    & ddr_cmd_pkg::local_addr_t'(low_mask(6'(cfg.bank_width)));
    // a zero cs_width gives an empty mask, so single chip maps to chip 0
    assign cs_src   = (local_addr >> cs_lsb)
                    & ddr_cmd_pkg::local_addr_t'(low_mask(6'(cfg.cs_width)));

    // a local beat spans 4 columns
    assign addr.col  = ddr_geom_pkg::col_t'(col_src << ddr_cmd_pkg::COL_SHIFT);
    assign addr.row  = ddr_geom_pkg::row_t'(row_src);
    assign addr.bank = ddr_geom_pkg::bank_t'(bank_src);
    assign addr.cs   = ddr_geom_pkg::cs_t'(cs_src);

    //////////////////////
    // csr range checks

    always_comb
    begin
        a_col_w: assert final (cfg.col_width inside {[4'd8:4'd12]})
            else $error("col_width %0d out of range", cfg.col_width);
        a_row_w: assert final (cfg.row_width inside {[5'd12:5'd16]})
            else $error("row_width %0d out of range", cfg.row_width);
        a_bank_w: assert final (cfg.bank_width inside {[2'd2:2'd3]})
            else $error("bank_width %0d out of range", cfg.bank_width);
        a_cs_w: assert final (cfg.cs_width <= 2'd2)
            else $error("cs_width %0d out of range", cfg.cs_width);
    end

endmodule

`default_nettype wire

/* src/ddr_addr_step.sv */
// command address stepper
// holds the address of the next follow-on command and moves it on by one
// burst per command, carrying into row, bank and chip with CSR wrap limits

`default_nettype none

module ddr_addr_step
(
    input  logic      ctl_clk,
    input  logic      ctl_reset_n,
    csr_cfg_if.cfg_in cfg,
    input  logic      load,         // request accepted, base is the first command
    input  logic      advance,      // follow-on command issued
    mem_addr_if.snk   base,
    mem_addr_if.src   addr
);

    ddr_geom_pkg::col_t  col_max;
    ddr_geom_pkg::row_t  row_max;
    ddr_geom_pkg::bank_t bank_max;
    ddr_geom_pkg::cs_t   cs_max;

    ddr_geom_pkg::col_t  src_col;
    ddr_geom_pkg::row_t  src_row;
    ddr_geom_pkg::bank_t src_bank;
    ddr_geom_pkg::cs_t   src_cs;

    ddr_geom_pkg::col_t  nxt_col;
    ddr_geom_pkg::row_t  nxt_row;
    ddr_geom_pkg::bank_t nxt_bank;
    ddr_geom_pkg::cs_t   nxt_cs;

    ddr_geom_pkg::col_t  col_q;
    ddr_geom_pkg::row_t  row_q;
    ddr_geom_pkg::bank_t bank_q;
    ddr_geom_pkg::cs_t   cs_q;

    logic col_last;
    logic row_last;
    logic bank_last;
    logic cs_last;
    logic row_inc;
    logic bank_inc;
    logic cs_inc;

    // top value of each field under the current csr widths
    assign col_max  = ddr_geom_pkg::col_t'((32'd1 << cfg.col_width) - 32'd1);
    assign row_max  = ddr_geom_pkg::row_t'((32'd1 << cfg.row_width) - 32'd1);
    assign bank_max = ddr_geom_pkg::bank_t'((32'd1 << cfg.bank_width) - 32'd1);
    assign cs_max   = ddr_geom_pkg::cs_t'((32'd1 << cfg.cs_width) - 32'd1);

    // step from the fresh mapped address on load, else from the held one
    assign src_col  = load ? base.col  : col_q;
    assign src_row  = load ? base.row  : row_q;
    assign src_bank = load ? base.bank : bank_q;
    assign src_cs   = load ? base.cs   : cs_q;

    //////////////////////
    // next address

    assign col_last  = (src_col >> ddr_geom_pkg::BURST_LSB)
                    == (col_max >> ddr_geom_pkg::BURST_LSB);
    assign row_last  = (src_row == row_max);
    assign bank_last = (src_bank == bank_max);
    assign cs_last   = (src_cs == cs_max);

    // carry order follows the address order, chip always last
    assign row_inc  = (cfg.addr_order == 2'd1) ? col_last : col_last & bank_last;
    assign bank_inc = (cfg.addr_order == 2'd1) ? col_last & row_last : col_last;
    assign cs_inc   = col_last & row_last & bank_last;

    always_comb
    begin
        if (col_last)
            nxt_col = '0;                           // end of column space
        else
            nxt_col = (src_col & ~ddr_geom_pkg::col_t'(ddr_geom_pkg::BURST_COLS - 1))
                    + ddr_geom_pkg::col_t'(ddr_geom_pkg::BURST_COLS);
        nxt_row  = row_inc  ? (row_last  ? '0 : src_row + 1'b1)  : src_row;
        nxt_bank = bank_inc ? (bank_last ? '0 : src_bank + 1'b1) : src_bank;
        nxt_cs   = cs_inc   ? (cs_last   ? '0 : src_cs + 1'b1)   : src_cs;
    end

    always_ff @(posedge ctl_clk)
    begin
        if (load || advance)
        begin
            col_q  <= nxt_col;
            row_q  <= nxt_row;
            bank_q <= nxt_bank;
            cs_q   <= nxt_cs;
        end
    end

    assign addr.col  = col_q;
    assign addr.row  = row_q;
    assign addr.bank = bank_q;
    assign addr.cs   = cs_q;

    // splitter only advances while a request is in flight
    a_load_adv: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        !(load && advance))
        else $error("load and advance high together");

endmodule

`default_nettype wire

/* src/ddr_burst_split.sv */
// burst splitter
// accepts a local request, issues its first command at once and the
// remaining beats as follow-on commands of up to one burst each

`default_nettype none

module ddr_burst_split
(
    input  logic                     ctl_clk,
    input  logic                     ctl_reset_n,
    input  logic                     local_read_req,
    input  logic                     local_write_req,
    input  ddr_cmd_pkg::local_size_t local_size,
    mem_addr_if.snk                  map_addr,
    mem_addr_if.snk                  step_addr,
    input  logic                     ready_in,
    output logic                     ready_out,
    output logic                     load,
    output logic                     advance,
    output logic                     read_req,
    output logic                     write_req,
    output ddr_cmd_pkg::cmd_size_t   size,
    output ddr_geom_pkg::cs_t        cs_addr,
    output ddr_geom_pkg::bank_t      bank_addr,
    output ddr_geom_pkg::row_t       row_addr,
    output ddr_geom_pkg::col_t       col_addr
);

    ddr_cmd_pkg::split_state_t state_q;
    logic                      is_read_q;    // kind of the request in flight
    ddr_cmd_pkg::local_size_t  rem_q;        // beats still to issue
    logic                      in_split;
    logic                      accept;
    logic                      unaligned;
    ddr_cmd_pkg::cmd_size_t    first_size;
    ddr_cmd_pkg::cmd_size_t    split_size;
    ddr_cmd_pkg::local_size_t  first_rem;

    assign in_split  = (state_q == ddr_cmd_pkg::SPLIT);
    assign ready_out = ready_in & ~in_split;
    assign accept    = ready_out & (local_read_req ^ local_write_req);

    //////////////////////
    // command sizing

    // first beat in the upper half of a burst
    assign unaligned  = map_addr.col[ddr_cmd_pkg::COL_SHIFT];
    assign first_size = (local_size == 1 || unaligned) ? 2'd1
                      : ddr_cmd_pkg::cmd_size_t'(ddr_cmd_pkg::BEATS_PER_BURST);
    assign first_rem  = local_size - ddr_cmd_pkg::local_size_t'(first_size);
    assign split_size = (rem_q >= ddr_cmd_pkg::BEATS_PER_BURST)
                      ? ddr_cmd_pkg::cmd_size_t'(ddr_cmd_pkg::BEATS_PER_BURST) : 2'd1;

    assign load    = accept;
    assign advance = in_split & ready_in;

    //////////////////////
    // state machine

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            state_q   <= ddr_cmd_pkg::IDLE;
            is_read_q <= 1'b0;
            rem_q     <= '0;
        end
        else
        begin
            case (state_q)
                ddr_cmd_pkg::IDLE:
                begin
                    if (accept && first_rem != '0)
                    begin
                        state_q   <= ddr_cmd_pkg::SPLIT;
                        is_read_q <= local_read_req;
                        rem_q     <= first_rem;
                    end
                end
                ddr_cmd_pkg::SPLIT:
                begin
                    if (ready_in)
                    begin
                        rem_q <= rem_q - ddr_cmd_pkg::local_size_t'(split_size);
                        if (rem_q <= ddr_cmd_pkg::BEATS_PER_BURST)
                            state_q <= ddr_cmd_pkg::IDLE;   // last command goes out
                    end
                end
            endcase
        end
    end

    //////////////////////
    // command outputs

    assign read_req  = in_split ? (is_read_q & ready_in)  : (accept & local_read_req);
    assign write_req = in_split ? (~is_read_q & ready_in) : (accept & local_write_req);
    assign size      = in_split ? split_size : first_size;

    // first command straight from the mapper, follow-ons from the stepper
    assign cs_addr   = in_split ? step_addr.cs   : map_addr.cs;
    assign bank_addr = in_split ? step_addr.bank : map_addr.bank;
    assign row_addr  = in_split ? step_addr.row  : map_addr.row;
    assign col_addr  = in_split ? step_addr.col  : map_addr.col;

    a_one_kind: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        (ready_out && local_read_req) |-> !local_write_req)
        else $error("read and write requested together");

    a_size_nz: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        accept |-> (local_size != '0))
        else $error("zero size request accepted");

    // a downstream stall freezes the splitter
    a_stall_hold: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        !ready_in |=> $stable(state_q) && $stable(rem_q) && $stable(is_read_q))
        else $error("splitter state moved while downstream not ready");

endmodule

`default_nettype wire

/* src/ddr_cmd_gen_top.sv */
// DDR command generator, half-rate
// remaps a local request into memory fields and splits it into
// burst-sized read or write commands toward the memory controller

`default_nettype none

module ddr_cmd_gen_top
(
    input  logic                      ctl_clk,
    input  logic                      ctl_reset_n,

    // local request
    input  logic                      local_read_req,
    input  logic                      local_write_req,
    input  ddr_cmd_pkg::local_size_t  local_size,
    input  ddr_cmd_pkg::local_addr_t  local_addr,

    // csr
    input  ddr_geom_pkg::addr_order_t addr_order,
    input  ddr_geom_pkg::csr_col_w_t  col_width,
    input  ddr_geom_pkg::csr_row_w_t  row_width,
    input  ddr_geom_pkg::csr_bank_w_t bank_width,
    input  ddr_geom_pkg::csr_cs_w_t   cs_width,

    input  logic                      ready_in,
    output logic                      ready_out,

    // memory command
    output logic                      read_req,
    output logic                      write_req,
    output ddr_cmd_pkg::cmd_size_t    size,
    output ddr_geom_pkg::cs_t         cs_addr,
    output ddr_geom_pkg::bank_t       bank_addr,
    output ddr_geom_pkg::row_t        row_addr,
    output ddr_geom_pkg::col_t        col_addr
);

    logic load;
    logic advance;

    csr_cfg_if  csr_cfg();
    mem_addr_if map_addr();
    mem_addr_if step_addr();

    assign csr_cfg.addr_order = addr_order;
    assign csr_cfg.col_width  = col_width;
    assign csr_cfg.row_width  = row_width;
    assign csr_cfg.bank_width = bank_width;
    assign csr_cfg.cs_width   = cs_width;

    ddr_addr_map u_addr_map
    (
        .cfg        (csr_cfg),
        .local_addr (local_addr),
        .addr       (map_addr)
    );

    ddr_addr_step u_addr_step
    (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .cfg         (csr_cfg),
        .load        (load),
        .advance     (advance),
        .base        (map_addr),
        .addr        (step_addr)
    );

    ddr_burst_split u_burst_split
    (
        .ctl_clk         (ctl_clk),
        .ctl_reset_n     (ctl_reset_n),
        .local_read_req  (local_read_req),
        .local_write_req (local_write_req),
        .local_size      (local_size),
        .map_addr        (map_addr),
        .step_addr       (step_addr),
        .ready_in        (ready_in),
        .ready_out       (ready_out),
        .load            (load),
        .advance         (advance),
        .read_req        (read_req),
        .write_req       (write_req),
        .size            (size),
        .cs_addr         (cs_addr),
        .bank_addr       (bank_addr),
        .row_addr        (row_addr),
        .col_addr        (col_addr)
    );

endmodule

`default_nettype wire

/* tb/ddr_cmd_model.svh */
// reference model of the command generator
// expands one accepted request into its expected command list,
// using the testbench CSR signals for widths and address order

`ifndef DDR_CMD_MODEL_SVH
`define DDR_CMD_MODEL_SVH

typedef struct packed {
    int unsigned               req_id;     // request the command belongs to
    logic                      is_read;
    ddr_cmd_pkg::cmd_size_t    size;
    ddr_geom_pkg::cs_t         cs;
    ddr_geom_pkg::bank_t       bank;
    ddr_geom_pkg::row_t        row;
    ddr_geom_pkg::col_t        col;
} exp_cmd_t;

exp_cmd_t exp_q[$];

// width bits of the address starting at lsb, empty when width is 0
function automatic longint unsigned field_of(input longint unsigned a, input int lsb,
                                             input int width);
    return (a >> lsb) % (64'd1 << width);
endfunction

function automatic exp_cmd_t map_request(input ddr_cmd_pkg::local_addr_t a);
    exp_cmd_t        c;
    longint unsigned la;
    int              col_bits;
    int              row_lsb;
    int              bank_lsb;
    int              cs_lsb;
    la       = 64'(a);
    col_bits = int'(col_width) - 2;
    if (addr_order == 2'd1)
    begin
        row_lsb  = col_bits;
        bank_lsb = col_bits + int'(row_width);
    end
    else
    begin
        bank_lsb = col_bits;
        row_lsb  = col_bits + int'(bank_width);
    end
    cs_lsb = col_bits + int'(row_width) + int'(bank_width);
    c      = '0;
    c.col  = 12'(field_of(la, 0, col_bits) * ddr_cmd_pkg::DWIDTH_RATIO);
    c.row  = 16'(field_of(la, row_lsb, int'(row_width)));
    c.bank = 3'(field_of(la, bank_lsb, int'(bank_width)));
    c.cs   = 2'(field_of(la, cs_lsb, int'(cs_width)));
    return c;
endfunction

// one burst further, carry through row and bank in address order, chip last
function automatic exp_cmd_t next_burst(input exp_cmd_t c);
    exp_cmd_t    n;
    int unsigned next_col;
    int unsigned row_v;
    int unsigned bank_v;
    logic        carry;
    n        = c;
    next_col = (int'(c.col) / ddr_geom_pkg::BURST_COLS + 1) * ddr_geom_pkg::BURST_COLS;
    if (next_col < (32'd1 << col_width))
    begin
        n.col = 12'(next_col);
        return n;
    end
    n.col  = '0;
    row_v  = int'(c.row);
    bank_v = int'(c.bank);
    if (addr_order == 2'd1)
    begin
        row_v = (row_v + 1) % (32'd1 << row_width);
        carry = (row_v == 0);
        if (carry)
        begin
            bank_v = (bank_v + 1) % (32'd1 << bank_width);
            carry  = (bank_v == 0);
        end
    end
    else
    begin
        bank_v = (bank_v + 1) % (32'd1 << bank_width);
        carry  = (bank_v == 0);
        if (carry)
        begin
            row_v = (row_v + 1) % (32'd1 << row_width);
            carry = (row_v == 0);
        end
    end
    n.row  = 16'(row_v);
    n.bank = 3'(bank_v);
    if (carry)
        n.cs = 2'((int'(c.cs) + 1) % (32'd1 << cs_width));   // zero width stays chip 0
    return n;
endfunction

task automatic expand_request(input int unsigned id, input logic is_read, input int sz,
                              input ddr_cmd_pkg::local_addr_t a);
    exp_cmd_t c;
    int       left;
    c         = map_request(a);
    c.req_id  = id;
    c.is_read = is_read;
    // upper half of a burst, or a single beat, goes out alone
    c.size    = (sz == 1 || c.col[ddr_cmd_pkg::COL_SHIFT]) ? 2'd1 : 2'd2;
    exp_q.push_back(c);
    left = sz - int'(c.size);
    while (left > 0)
    begin
        c      = next_burst(c);
        c.size = (left >= 2) ? 2'd2 : 2'd1;
        exp_q.push_back(c);
        left = left - int'(c.size);
    end
endtask

`endif

/* tb/tb_ddr_cmd_gen.sv */
// testbench of the DDR command generator
// random CSR phases and requests under random back-pressure, every
// issued command compared with the reference model queue

`default_nettype none

module tb_ddr_cmd_gen;

    localparam int N_PHASES    = 8;
    localparam int N_REQS      = 60;
    localparam int CYCLE_LIMIT = N_PHASES * N_REQS * 32 * 4 + 1000;

    logic                      ctl_clk;
    logic                      ctl_reset_n;
    logic                      local_read_req;
    logic                      local_write_req;
    ddr_cmd_pkg::local_size_t  local_size;
    ddr_cmd_pkg::local_addr_t  local_addr;
    ddr_geom_pkg::addr_order_t addr_order;
    ddr_geom_pkg::csr_col_w_t  col_width;
    ddr_geom_pkg::csr_row_w_t  row_width;
    ddr_geom_pkg::csr_bank_w_t bank_width;
    ddr_geom_pkg::csr_cs_w_t   cs_width;
    logic                      ready_in;
    logic                      ready_out;
    logic                      read_req;
    logic                      write_req;
    ddr_cmd_pkg::cmd_size_t    size;
    ddr_geom_pkg::cs_t         cs_addr;
    ddr_geom_pkg::bank_t       bank_addr;
    ddr_geom_pkg::row_t        row_addr;
    ddr_geom_pkg::col_t        col_addr;

    int unsigned checks       = 0;
    int unsigned errors       = 0;
    int unsigned req_count    = 0;
    int unsigned cycle_count  = 0;
    logic        accepted_now = 1'b0;   // request taken in the cycle just sampled
    logic        exp_ready;

    `include "ddr_cmd_model.svh"

    exp_cmd_t got;

    ddr_cmd_gen_top u_dut
    (
        .ctl_clk         (ctl_clk),
        .ctl_reset_n     (ctl_reset_n),
        .local_read_req  (local_read_req),
        .local_write_req (local_write_req),
        .local_size      (local_size),
        .local_addr      (local_addr),
        .addr_order      (addr_order),
        .col_width       (col_width),
        .row_width       (row_width),
        .bank_width      (bank_width),
        .cs_width        (cs_width),
        .ready_in        (ready_in),
        .ready_out       (ready_out),
        .read_req        (read_req),
        .write_req       (write_req),
        .size            (size),
        .cs_addr         (cs_addr),
        .bank_addr       (bank_addr),
        .row_addr        (row_addr),
        .col_addr        (col_addr)
    );

    initial
    begin
        ctl_clk = 1'b0;
        forever #50 ctl_clk = ~ctl_clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    endtask

    ////////////////////
    // stimulus

    task automatic pick_config(input int phase);
        @(posedge ctl_clk);
        col_width  <= 4'($urandom_range(8, 12));
        row_width  <= 5'($urandom_range(12, 16));
        bank_width <= 2'($urandom_range(2, 3));
        // first two phases run single chip, one per address order
        cs_width   <= (phase < 2) ? 2'd0 : 2'($urandom_range(0, 2));
        addr_order <= (phase == 0) ? 2'd1 : (phase == 1) ? 2'd0 : 2'($urandom_range(0, 3));
    endtask

    task automatic send_request();
        int              total;
        longint unsigned top;
        logic            is_read;
        @(posedge ctl_clk);
        total   = int'(col_width) - 2 + int'(row_width) + int'(bank_width) + int'(cs_width);
        top     = (64'd1 << total) - 64'd1;
        is_read = 1'($urandom_range(0, 1));
        local_read_req  <= is_read;
        local_write_req <= !is_read;
        if ($urandom_range(0, 3) == 0)
            local_size <= 6'($urandom_range(1, 2));
        else
            local_size <= 6'($urandom_range(1, 63));
        if ($urandom_range(0, 7) == 0)
            local_addr <= 33'(top - 64'($urandom_range(0, 31)));    // near the top, wraps
        else
            local_addr <= 33'({$urandom(), $urandom()});
        @(posedge ctl_clk);
        while (!accepted_now)
            @(posedge ctl_clk);
        local_read_req  <= 1'b0;
        local_write_req <= 1'b0;
        repeat ($urandom_range(0, 2)) @(posedge ctl_clk);
    endtask

    // ready_in high about 70 percent of cycles
    always @(posedge ctl_clk)
        ready_in <= ($urandom_range(0, 9) < 7);

    initial
    begin
        void'($urandom(27));
        ctl_reset_n     = 1'b0;
        local_read_req  = 1'b0;
        local_write_req = 1'b0;
        local_size      = 6'd1;
        local_addr      = '0;
        addr_order      = 2'd0;
        col_width       = 4'd10;
        row_width       = 5'd14;
        bank_width      = 2'd3;
        cs_width        = 2'd1;
        ready_in        = 1'b0;
        repeat (10) @(posedge ctl_clk);
        ctl_reset_n <= 1'b1;
        repeat (5) @(posedge ctl_clk);      // idle, no commands expected
        for (int phase = 0; phase < N_PHASES; phase++)
        begin
            pick_config(phase);
            for (int i = 0; i < N_REQS; i++)
                send_request();
            while (exp_q.size() != 0)
                @(posedge ctl_clk);
            @(posedge ctl_clk);
        end
        repeat (5) @(posedge ctl_clk);
        finish_run();
    end

    ////////////////////
    // monitor, sampled mid-cycle

    always @(negedge ctl_clk)
    begin
        exp_ready = ready_in && (exp_q.size() == 0);
        check_value("ready_out", 64'(exp_ready), 64'(ready_out));
        accepted_now = exp_ready && (local_read_req ^ local_write_req);
        if (accepted_now)
        begin
            req_count++;
            expand_request(req_count, local_read_req, int'(local_size), local_addr);
        end
        if (read_req || write_req)
        begin
            if (!ready_in)
            begin
                errors++;
                $display("command issued while ready_in is low");
            end
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("command issued with no command expected");
            end
            else
            begin
                got = exp_q.pop_front();
                check_value($sformatf("req%0d kind", got.req_id),
                            got.is_read ? 64'd2 : 64'd1, 64'({read_req, write_req}));
                check_value($sformatf("req%0d size", got.req_id), 64'(got.size), 64'(size));
                check_value($sformatf("req%0d cs", got.req_id), 64'(got.cs), 64'(cs_addr));
                check_value($sformatf("req%0d bank", got.req_id), 64'(got.bank),
                            64'(bank_addr));
                check_value($sformatf("req%0d row", got.req_id), 64'(got.row), 64'(row_addr));
                check_value($sformatf("req%0d col", got.req_id), 64'(got.col), 64'(col_addr));
            end
        end
    end

    always @(posedge ctl_clk)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            errors++;
            $display("run hung, cycle limit of %0d reached", CYCLE_LIMIT);
            finish_run();
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tb
src/ddr_geom_pkg.sv
src/ddr_cmd_pkg.sv
src/ddr_cmd_ifs.sv
src/ddr_addr_map.sv
src/ddr_addr_step.sv
src/ddr_burst_split.sv
src/ddr_cmd_gen_top.sv
tb/tb_ddr_cmd_gen.sv

/* Makefile */
# Verilator build of the DDR command generator testbench

VERILATOR ?= verilator
TOP       ?= tb_ddr_cmd_gen
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

SOURCES := $(wildcard src/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
